// File: cpu_pkg.sv
`default_nettype none

package cpu_pkg;

  localparam int data_w     = 32;
  localparam int reg_addr_w = 5;
  localparam int opcode_w   = 6;
  localparam int imm_w      = 16;
  localparam int shamt_w    = 5;

  // instruction field positions
  localparam int op_msb    = 31;
  localparam int op_lsb    = 26;
  localparam int rs_msb    = 25;
  localparam int rs_lsb    = 21;
  localparam int rt_msb    = 20;
  localparam int rt_lsb    = 16;
  localparam int rd_msb    = 15;
  localparam int rd_lsb    = 11;
  localparam int shamt_msb = 10;
  localparam int shamt_lsb = 6;
  localparam int imm_msb   = 15;
  localparam int imm_lsb   = 0;

  ////////////////////////////////////////////////////////////////////////////
  // encodings
  ////////////////////////////////////////////////////////////////////////////

  // an all-zero word is a nop, so a cleared register is a bubble
  typedef enum logic [opcode_w-1:0] {
    op_nop  = 6'd0,
    op_add  = 6'd1,
    op_sub  = 6'd2,
    op_and  = 6'd3,
    op_or   = 6'd4,
    op_xor  = 6'd5,
    op_slt  = 6'd6,
    op_sll  = 6'd7,
    op_srl  = 6'd8,
    op_addi = 6'd9,
    op_ori  = 6'd10,
    op_lw   = 6'd11,
    op_sw   = 6'd12,
    op_beq  = 6'd13,
    op_bne  = 6'd14,
    op_j    = 6'd15,
    op_jr   = 6'd16,
    op_halt = 6'd17
  } opcode_t;

  typedef enum logic [2:0] {
    alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_slt, alu_sll, alu_srl
  } alu_op_t;

  typedef enum logic [1:0] {mem_none, mem_read, mem_write} mem_op_t;

  typedef enum logic [2:0] {jmp_none, jmp_beq, jmp_bne, jmp_abs, jmp_reg} jump_op_t;

  typedef enum logic [1:0] {fwd_reg, fwd_mem_wb, fwd_ex_mem} fwd_sel_t;

  ////////////////////////////////////////////////////////////////////////////
  // pipeline registers and ports
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [data_w-1:0] instr;
    logic [data_w-1:0] pc;
  } if_id_t;

  typedef struct packed {
    logic [reg_addr_w-1:0] rs;
    logic [reg_addr_w-1:0] rt;
    logic [reg_addr_w-1:0] dst;
    logic [data_w-1:0]     rs_val;
    logic [data_w-1:0]     rt_val;
    logic [imm_w-1:0]      imm;
    logic [shamt_w-1:0]    shamt;
    alu_op_t               alu_op;
    mem_op_t               mem_op;
    jump_op_t              jump_op;
    logic                  alu_src_imm;
    logic                  mem_to_reg;
    logic                  reg_write;
    logic                  halt;
  } id_ex_t;

  typedef struct packed {
    logic [data_w-1:0]     result;
    logic [data_w-1:0]     store_data;
    logic [reg_addr_w-1:0] dst;
    mem_op_t               mem_op;
    logic                  mem_to_reg;
    logic                  reg_write;
    logic                  halt;
  } ex_mem_t;

  typedef struct packed {
    logic [data_w-1:0]     result;
    logic [data_w-1:0]     load_data;
    logic [reg_addr_w-1:0] dst;
    logic                  mem_to_reg;
    logic                  reg_write;
    logic                  halt;
  } mem_wb_t;

  typedef struct packed {
    logic                  valid;
    logic [reg_addr_w-1:0] idx;
    logic [data_w-1:0]     data;
  } wb_trace_t;

  typedef struct packed {
    logic              taken;
    logic [data_w-1:0] target;
  } redirect_t;

endpackage

`default_nettype wire

// File: fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit #(
  parameter int imem_aw = 8
) (
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire                          stall,
  input  wire                          halt_fetch,
  input  wire cpu_pkg::redirect_t      redirect,
  input  wire                          prog_we,
  input  wire [imem_aw-1:0]            prog_addr,
  input  wire [cpu_pkg::data_w-1:0]    prog_data,
  output cpu_pkg::if_id_t              if_id
);
  import cpu_pkg::*;

  logic [data_w-1:0] imem [2**imem_aw];
  logic [data_w-1:0] pc;
  logic [data_w-1:0] instr;

  // program load port, used while the core sits in reset
  always_ff @(posedge clk) begin
    if (prog_we) begin
      imem[prog_addr] <= prog_data;
    end
  end

  // word addressed, pc counts instructions
  assign instr = imem[pc[imem_aw-1:0]];

  // redirect beats stall, stall beats halt
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc    <= '0;
      if_id <= '0;
    end else if (redirect.taken) begin
      pc    <= redirect.target;
      if_id <= '0;
    end else if (!stall) begin
      if (halt_fetch) begin
        // pc parks on the word after halt
        if_id <= '0;
      end else begin
        pc          <= pc + 1'b1;
        if_id.instr <= instr;
        if_id.pc    <= pc;
      end
    end
  end

endmodule

`default_nettype wire

// File: register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file (
  input  wire                           clk,
  input  wire                           rst_n,
  input  wire [cpu_pkg::reg_addr_w-1:0] rd_addr_a,
  input  wire [cpu_pkg::reg_addr_w-1:0] rd_addr_b,
  input  wire cpu_pkg::mem_wb_t         wr,
  input  wire [cpu_pkg::data_w-1:0]     wr_data,
  output logic [cpu_pkg::data_w-1:0]    rd_data_a,
  output logic [cpu_pkg::data_w-1:0]    rd_data_b
);
  import cpu_pkg::*;

  logic [data_w-1:0] regs [2**reg_addr_w];
  logic              wr_en;

  // writes to r0 are dropped
  assign wr_en = wr.reg_write && (wr.dst != '0);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < 2**reg_addr_w; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wr.dst] <= wr_data;
    end
  end

  // write-first: a same-cycle write shows up on the read ports
  assign rd_data_a = (rd_addr_a == '0) ? '0 :
                     (wr_en && wr.dst == rd_addr_a) ? wr_data : regs[rd_addr_a];
  assign rd_data_b = (rd_addr_b == '0) ? '0 :
                     (wr_en && wr.dst == rd_addr_b) ? wr_data : regs[rd_addr_b];

endmodule

`default_nettype wire

// File: decode_unit.sv
`timescale 1ns/1ps
`default_nettype none

module decode_unit (
  input  wire                            clk,
  input  wire                            rst_n,
  input  wire cpu_pkg::if_id_t           if_id,
  input  wire cpu_pkg::redirect_t        redirect,
  input  wire [cpu_pkg::data_w-1:0]      rd_data_a,
  input  wire [cpu_pkg::data_w-1:0]      rd_data_b,
  output logic [cpu_pkg::reg_addr_w-1:0] rd_addr_a,
  output logic [cpu_pkg::reg_addr_w-1:0] rd_addr_b,
  output logic                           stall,
  output logic                           halt_fetch,
  output cpu_pkg::id_ex_t                id_ex
);
  import cpu_pkg::*;

  opcode_t               opcode;
  logic [reg_addr_w-1:0] rs;
  logic [reg_addr_w-1:0] rt;
  logic [reg_addr_w-1:0] rd;
  logic [reg_addr_w-1:0] dst;
  alu_op_t               alu_op;
  mem_op_t               mem_op;
  jump_op_t              jump_op;
  logic                  alu_src_imm;
  logic                  mem_to_reg;
  logic                  wr_en;
  logic                  dst_is_rd;
  logic                  uses_rs;
  logic                  uses_rt;
  logic                  is_halt;
  logic                  halt_seen;

  assign opcode = opcode_t'(if_id.instr[op_msb:op_lsb]);
  assign rs     = if_id.instr[rs_msb:rs_lsb];
  assign rt     = if_id.instr[rt_msb:rt_lsb];
  assign rd     = if_id.instr[rd_msb:rd_lsb];

  assign rd_addr_a = rs;
  assign rd_addr_b = rt;

  // control decode, unknown opcodes fall through as nop
  always_comb begin
    alu_op      = alu_add;
    mem_op      = mem_none;
    jump_op     = jmp_none;
    alu_src_imm = 1'b0;
    mem_to_reg  = 1'b0;
    wr_en       = 1'b0;
    dst_is_rd   = 1'b0;
    uses_rs     = 1'b0;
    uses_rt     = 1'b0;
    is_halt     = 1'b0;
    case (opcode)
      op_add, op_sub, op_and, op_or, op_xor, op_slt: begin
        wr_en     = 1'b1;
        dst_is_rd = 1'b1;
        uses_rs   = 1'b1;
        uses_rt   = 1'b1;
        case (opcode)
          op_sub:  alu_op = alu_sub;
          op_and:  alu_op = alu_and;
          op_or:   alu_op = alu_or;
          op_xor:  alu_op = alu_xor;
          op_slt:  alu_op = alu_slt;
          default: alu_op = alu_add;
        endcase
      end
      // shifts move rs by shamt, rt is not read
      op_sll, op_srl: begin
        alu_op    = (opcode == op_sll) ? alu_sll : alu_srl;
        wr_en     = 1'b1;
        dst_is_rd = 1'b1;
        uses_rs   = 1'b1;
      end
      op_addi, op_ori, op_lw: begin
        alu_op      = (opcode == op_ori) ? alu_or : alu_add;
        alu_src_imm = 1'b1;
        wr_en       = 1'b1;
        uses_rs     = 1'b1;
        mem_op      = (opcode == op_lw) ? mem_read : mem_none;
        mem_to_reg  = (opcode == op_lw);
      end
      op_sw: begin
        alu_src_imm = 1'b1;
        mem_op      = mem_write;
        uses_rs     = 1'b1;
        uses_rt     = 1'b1;
      end
      op_beq, op_bne: begin
        jump_op = (opcode == op_beq) ? jmp_beq : jmp_bne;
        uses_rs = 1'b1;
        uses_rt = 1'b1;
      end
      op_j:    jump_op = jmp_abs;
      op_jr: begin
        jump_op = jmp_reg;
        uses_rs = 1'b1;
      end
      op_halt: is_halt = 1'b1;
      default: ;
    endcase
  end

  assign dst = dst_is_rd ? rd : rt;

  // load-use: the load in id_ex writes a register this instruction reads
  assign stall = id_ex.mem_op == mem_read && id_ex.reg_write &&
                 ((uses_rs && rs == id_ex.dst) || (uses_rt && rt == id_ex.dst));

  // fetch stays parked once a halt is seen, until a redirect flushes it
  always_ff @(posedge clk) begin
    if (!rst_n || redirect.taken) begin
      halt_seen <= 1'b0;
    end else if (is_halt) begin
      halt_seen <= 1'b1;
    end
  end

  assign halt_fetch = is_halt || halt_seen;

  always_ff @(posedge clk) begin
    if (!rst_n || stall || redirect.taken) begin
      id_ex <= '0;
    end else begin
      id_ex.rs          <= rs;
      id_ex.rt          <= rt;
      id_ex.dst         <= dst;
      id_ex.rs_val      <= rd_data_a;
      id_ex.rt_val      <= rd_data_b;
      id_ex.imm         <= if_id.instr[imm_msb:imm_lsb];
      id_ex.shamt       <= if_id.instr[shamt_msb:shamt_lsb];
      id_ex.alu_op      <= alu_op;
      id_ex.mem_op      <= mem_op;
      id_ex.jump_op     <= jump_op;
      id_ex.alu_src_imm <= alu_src_imm;
      id_ex.mem_to_reg  <= mem_to_reg;
      id_ex.reg_write   <= wr_en && (dst != '0);
      id_ex.halt        <= is_halt;
    end
  end

endmodule

`default_nettype wire

// File: execute_unit.sv
`timescale 1ns/1ps
`default_nettype none

module execute_unit (
  input  wire                        clk,
  input  wire                        rst_n,
  input  wire cpu_pkg::id_ex_t       id_ex,
  input  wire cpu_pkg::ex_mem_t      ex_mem_fwd,
  input  wire cpu_pkg::mem_wb_t      mem_wb_fwd,
  input  wire [cpu_pkg::data_w-1:0]  wb_data,
  output cpu_pkg::redirect_t         redirect,
  output cpu_pkg::ex_mem_t           ex_mem
);
  import cpu_pkg::*;

  fwd_sel_t          fwd_a;
  fwd_sel_t          fwd_b;
  logic [data_w-1:0] op_a;
  logic [data_w-1:0] op_b;
  logic [data_w-1:0] imm_ext;
  logic [data_w-1:0] alu_b;
  logic [data_w-1:0] alu_res;

  ////////////////////////////////////////////////////////////////////////////
  // forwarding
  ////////////////////////////////////////////////////////////////////////////

  // ex/mem is younger than mem/wb, so it is checked first
  function automatic fwd_sel_t pick_src(
    input logic [reg_addr_w-1:0] src,
    input ex_mem_t               em,
    input mem_wb_t               mw
  );
    fwd_sel_t sel;
    sel = fwd_reg;
    if (src != '0 && em.reg_write && em.dst == src) begin
      sel = fwd_ex_mem;
    end else if (src != '0 && mw.reg_write && mw.dst == src) begin
      sel = fwd_mem_wb;
    end
    return sel;
  endfunction

  function automatic logic [data_w-1:0] fwd_value(
    input fwd_sel_t          sel,
    input logic [data_w-1:0] reg_val,
    input logic [data_w-1:0] em_val,
    input logic [data_w-1:0] wb_val
  );
    case (sel)
      fwd_ex_mem: return em_val;
      fwd_mem_wb: return wb_val;
      default:    return reg_val;
    endcase
  endfunction

  assign fwd_a = pick_src(id_ex.rs, ex_mem_fwd, mem_wb_fwd);
  assign fwd_b = pick_src(id_ex.rt, ex_mem_fwd, mem_wb_fwd);
  assign op_a  = fwd_value(fwd_a, id_ex.rs_val, ex_mem_fwd.result, wb_data);
  assign op_b  = fwd_value(fwd_b, id_ex.rt_val, ex_mem_fwd.result, wb_data);

  ////////////////////////////////////////////////////////////////////////////
  // alu
  ////////////////////////////////////////////////////////////////////////////

  assign imm_ext = {{(data_w-imm_w){1'b0}}, id_ex.imm};
  assign alu_b   = id_ex.alu_src_imm ? imm_ext : op_b;

  always_comb begin
    case (id_ex.alu_op)
      alu_sub: alu_res = op_a - alu_b;
      alu_and: alu_res = op_a & alu_b;
      alu_or:  alu_res = op_a | alu_b;
      alu_xor: alu_res = op_a ^ alu_b;
      alu_slt: alu_res = {{(data_w-1){1'b0}}, $signed(op_a) < $signed(alu_b)};
      alu_sll: alu_res = op_a << id_ex.shamt;
      alu_srl: alu_res = op_a >> id_ex.shamt;
      default: alu_res = op_a + alu_b;
    endcase
  end

  // branch and jump resolution, targets are absolute word addresses
  always_comb begin
    redirect.taken  = 1'b0;
    redirect.target = imm_ext;
    case (id_ex.jump_op)
      jmp_beq: redirect.taken = (op_a == op_b);
      jmp_bne: redirect.taken = (op_a != op_b);
      jmp_abs: redirect.taken = 1'b1;
      jmp_reg: begin
        redirect.taken  = 1'b1;
        redirect.target = op_a;
      end
      default: redirect.taken = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ex_mem <= '0;
    end else begin
      ex_mem.result     <= alu_res;
      ex_mem.store_data <= op_b;
      ex_mem.dst        <= id_ex.dst;
      ex_mem.mem_op     <= id_ex.mem_op;
      ex_mem.mem_to_reg <= id_ex.mem_to_reg;
      ex_mem.reg_write  <= id_ex.reg_write;
      ex_mem.halt       <= id_ex.halt;
    end
  end

endmodule

`default_nettype wire

// File: memory_unit.sv
`timescale 1ns/1ps
`default_nettype none

module memory_unit #(
  parameter int dmem_aw = 8
) (
  input  wire                        clk,
  input  wire                        rst_n,
  input  wire cpu_pkg::ex_mem_t      ex_mem,
  output cpu_pkg::mem_wb_t           mem_wb,
  output logic [cpu_pkg::data_w-1:0] wb_data,
  output cpu_pkg::wb_trace_t         trace,
  output logic                       halted
);
  import cpu_pkg::*;

  logic [data_w-1:0]  dmem [2**dmem_aw];
  logic [dmem_aw-1:0] addr;
  logic [data_w-1:0]  load_data;
  logic               halt_seen;

  // word address straight from the alu result
  assign addr      = ex_mem.result[dmem_aw-1:0];
  assign load_data = dmem[addr];

  always_ff @(posedge clk) begin
    if (ex_mem.mem_op == mem_write) begin
      dmem[addr] <= ex_mem.store_data;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mem_wb <= '0;
    end else begin
      mem_wb.result     <= ex_mem.result;
      mem_wb.load_data  <= load_data;
      mem_wb.dst        <= ex_mem.dst;
      mem_wb.mem_to_reg <= ex_mem.mem_to_reg;
      mem_wb.reg_write  <= ex_mem.reg_write;
      mem_wb.halt       <= ex_mem.halt;
    end
  end

  // writeback select
  assign wb_data = mem_wb.mem_to_reg ? mem_wb.load_data : mem_wb.result;

  assign trace.valid = mem_wb.reg_write;
  assign trace.idx   = mem_wb.dst;
  assign trace.data  = wb_data;

  // stays high once the halt has reached mem/wb
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      halt_seen <= 1'b0;
    end else if (mem_wb.halt) begin
      halt_seen <= 1'b1;
    end
  end

  assign halted = mem_wb.halt || halt_seen;

endmodule

`default_nettype wire

// File: processor.sv
`timescale 1ns/1ps
`default_nettype none

module processor #(
  parameter int imem_aw = 8,
  parameter int dmem_aw = 8
) (
  input  wire                       clk,
  input  wire                       rst_n,
  input  wire                       prog_we,
  input  wire [imem_aw-1:0]         prog_addr,
  input  wire [cpu_pkg::data_w-1:0] prog_data,
  output cpu_pkg::wb_trace_t        trace,
  output logic                      halted
);
  import cpu_pkg::*;

  if_id_t                if_id;
  id_ex_t                id_ex;
  ex_mem_t               ex_mem;
  mem_wb_t               mem_wb;
  redirect_t             redirect;
  logic                  stall;
  logic                  halt_fetch;
  logic [reg_addr_w-1:0] rd_addr_a;
  logic [reg_addr_w-1:0] rd_addr_b;
  logic [data_w-1:0]     rd_data_a;
  logic [data_w-1:0]     rd_data_b;
  logic [data_w-1:0]     wb_data;

  ////////////////////////////////////////////////////////////////////////////
  // fetch and decode
  ////////////////////////////////////////////////////////////////////////////

  fetch_unit #(.imem_aw(imem_aw)) u_fetch (
    .clk        (clk),
    .rst_n      (rst_n),
    .stall      (stall),
    .halt_fetch (halt_fetch),
    .redirect   (redirect),
    .prog_we    (prog_we),
    .prog_addr  (prog_addr),
    .prog_data  (prog_data),
    .if_id      (if_id)
  );

  decode_unit u_decode (
    .clk        (clk),
    .rst_n      (rst_n),
    .if_id      (if_id),
    .redirect   (redirect),
    .rd_data_a  (rd_data_a),
    .rd_data_b  (rd_data_b),
    .rd_addr_a  (rd_addr_a),
    .rd_addr_b  (rd_addr_b),
    .stall      (stall),
    .halt_fetch (halt_fetch),
    .id_ex      (id_ex)
  );

  // written from mem/wb, read in decode
  register_file u_regs (
    .clk       (clk),
    .rst_n     (rst_n),
    .rd_addr_a (rd_addr_a),
    .rd_addr_b (rd_addr_b),
    .wr        (mem_wb),
    .wr_data   (wb_data),
    .rd_data_a (rd_data_a),
    .rd_data_b (rd_data_b)
  );

  ////////////////////////////////////////////////////////////////////////////
  // execute, memory and writeback
  ////////////////////////////////////////////////////////////////////////////

  execute_unit u_execute (
    .clk        (clk),
    .rst_n      (rst_n),
    .id_ex      (id_ex),
    .ex_mem_fwd (ex_mem),
    .mem_wb_fwd (mem_wb),
    .wb_data    (wb_data),
    .redirect   (redirect),
    .ex_mem     (ex_mem)
  );

  memory_unit #(.dmem_aw(dmem_aw)) u_memory (
    .clk     (clk),
    .rst_n   (rst_n),
    .ex_mem  (ex_mem),
    .mem_wb  (mem_wb),
    .wb_data (wb_data),
    .trace   (trace),
    .halted  (halted)
  );

endmodule

`default_nettype wire

// File: tb_processor.sv
`timescale 1ns/1ps
`default_nettype none

module tb_processor;
  import cpu_pkg::*;

  localparam int imem_aw   = 8;
  localparam int dmem_aw   = 8;
  localparam int num_tests = 5;
  localparam int prog_len  = 16;
  localparam int halt_wait = 500;
  localparam logic [31:0] halt_word = {op_halt, 26'd0};
  localparam logic [15:0] marker    = 16'h0bad;

  logic              clk;
  logic              rst_n;
  logic              prog_we;
  logic [imem_aw-1:0] prog_addr;
  logic [31:0]       prog_data;
  wb_trace_t         trace;
  logic              halted;

  // test table
  string       test_name [num_tests];
  logic [31:0] prog_tbl  [num_tests][prog_len];
  logic [4:0]  chk_reg   [num_tests];
  logic [31:0] chk_exp   [num_tests];

  // reference model state and expected writes
  logic [31:0] model_regs [32];
  logic [31:0] model_mem  [256];
  logic [4:0]  exp_idx  [$];
  logic [31:0] exp_data [$];

  // writes seen on the trace port
  logic [4:0]  got_idx  [$];
  logic [31:0] got_data [$];
  logic        capture;
  int          post_halt_writes;

  logic [7:0]  lfsr_state;
  int          error_count;
  int          check_count;

  processor #(.imem_aw(imem_aw), .dmem_aw(dmem_aw)) uut (
    .clk       (clk),
    .rst_n     (rst_n),
    .prog_we   (prog_we),
    .prog_addr (prog_addr),
    .prog_data (prog_data),
    .trace     (trace),
    .halted    (halted)
  );

  always #10 clk = ~clk;

  // sampled at the falling edge where trace is stable
  always @(negedge clk) begin
    if (capture && trace.valid) begin
      got_idx.push_back(trace.idx);
      got_data.push_back(trace.data);
      if (halted) begin
        post_halt_writes++;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // instruction encoding and random immediates
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] r_word(opcode_t op, logic [4:0] rd, logic [4:0] rs,
                                          logic [4:0] rt);
    return {op, rs, rt, rd, 11'd0};
  endfunction

  function automatic logic [31:0] shift_word(opcode_t op, logic [4:0] rd, logic [4:0] rs,
                                              logic [4:0] shamt);
    return {op, rs, 5'd0, rd, shamt, 6'd0};
  endfunction

  // branches use the same layout with rs and rt compared and imm as the target
  function automatic logic [31:0] i_word(opcode_t op, logic [4:0] rt, logic [4:0] rs,
                                          logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic logic [31:0] j_word(opcode_t op, logic [4:0] rs, logic [15:0] target);
    return {op, rs, 5'd0, target};
  endfunction

  // galois form with taps for x^8 + x^6 + x^5 + x^4 + 1
  function automatic logic [7:0] lfsr_next(logic [7:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 8'hb8;
    end else begin
      return s >> 1;
    end
  endfunction

  task automatic rand_imm(output logic [15:0] v);
    v = '0;
    for (int b = 0; b < 16; b++) begin
      v = {v[14:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // programs
  ////////////////////////////////////////////////////////////////////////////

  task automatic build_table();
    logic [15:0] imm_a;
    logic [15:0] imm_b;
    for (int t = 0; t < num_tests; t++) begin
      for (int i = 0; i < prog_len; i++) begin
        prog_tbl[t][i] = halt_word;
      end
    end
    rand_imm(imm_a);
    rand_imm(imm_b);

    // back-to-back dependent chain with sources one and two slots back
    test_name[0] = "alu_chain";
    prog_tbl[0][0]  = i_word(op_addi, 1, 0, imm_a);
    prog_tbl[0][1]  = i_word(op_ori, 2, 0, imm_b);
    prog_tbl[0][2]  = r_word(op_add, 3, 1, 2);
    prog_tbl[0][3]  = r_word(op_sub, 4, 3, 1);
    prog_tbl[0][4]  = r_word(op_and, 5, 4, 3);
    prog_tbl[0][5]  = r_word(op_or, 6, 5, 1);
    prog_tbl[0][6]  = r_word(op_xor, 7, 6, 4);
    prog_tbl[0][7]  = r_word(op_sub, 8, 0, 7);
    prog_tbl[0][8]  = r_word(op_slt, 9, 8, 1);
    prog_tbl[0][9]  = r_word(op_slt, 10, 1, 8);
    prog_tbl[0][10] = shift_word(op_sll, 11, 7, 4);
    prog_tbl[0][11] = shift_word(op_srl, 12, 8, 3);
    prog_tbl[0][12] = r_word(op_add, 13, 11, 12);
    prog_tbl[0][13] = r_word(op_xor, 14, 13, 9);
    chk_reg[0] = 14;
    chk_exp[0] = 32'd0;

    // store, reload, and use the loaded value at once
    test_name[1] = "mem_load_use";
    prog_tbl[1][0]  = i_word(op_addi, 1, 0, 16'h1234);
    prog_tbl[1][1]  = i_word(op_addi, 2, 0, 16'd5);
    prog_tbl[1][2]  = i_word(op_sw, 1, 2, 16'd3);
    prog_tbl[1][3]  = i_word(op_lw, 3, 2, 16'd3);
    prog_tbl[1][4]  = r_word(op_add, 4, 3, 1);
    prog_tbl[1][5]  = i_word(op_lw, 5, 0, 16'd8);
    prog_tbl[1][6]  = r_word(op_add, 6, 5, 5);
    prog_tbl[1][7]  = i_word(op_sw, 6, 0, 16'd9);
    prog_tbl[1][8]  = i_word(op_lw, 7, 0, 16'd9);
    prog_tbl[1][9]  = r_word(op_add, 8, 7, 4);
    chk_reg[1] = 8;
    chk_exp[1] = 32'h0000_48d0;

    // r20 and up are markers on the wrong path
    test_name[2] = "branches";
    prog_tbl[2][0]  = i_word(op_addi, 1, 0, 16'd7);
    prog_tbl[2][1]  = i_word(op_addi, 2, 0, 16'd7);
    prog_tbl[2][2]  = i_word(op_beq, 2, 1, 16'd5);
    prog_tbl[2][3]  = i_word(op_addi, 20, 0, marker);
    prog_tbl[2][4]  = i_word(op_addi, 21, 0, marker);
    prog_tbl[2][5]  = i_word(op_addi, 3, 0, 16'd1);
    prog_tbl[2][6]  = i_word(op_bne, 2, 1, 16'd9);
    prog_tbl[2][7]  = i_word(op_addi, 4, 0, 16'd2);
    prog_tbl[2][8]  = i_word(op_beq, 3, 1, 16'd12);
    prog_tbl[2][9]  = i_word(op_addi, 5, 0, 16'd3);
    prog_tbl[2][10] = i_word(op_bne, 3, 1, 16'd13);
    prog_tbl[2][11] = i_word(op_addi, 22, 0, marker);
    prog_tbl[2][12] = i_word(op_addi, 23, 0, marker);
    prog_tbl[2][13] = i_word(op_addi, 6, 0, 16'd4);
    chk_reg[2] = 6;
    chk_exp[2] = 32'd4;

    test_name[3] = "jumps";
    prog_tbl[3][0]  = i_word(op_addi, 2, 0, 16'd11);
    prog_tbl[3][1]  = j_word(op_j, 0, 16'd4);
    prog_tbl[3][2]  = i_word(op_addi, 20, 0, marker);
    prog_tbl[3][3]  = i_word(op_addi, 21, 0, marker);
    prog_tbl[3][4]  = i_word(op_addi, 1, 0, 16'd9);
    prog_tbl[3][5]  = j_word(op_jr, 1, 16'd0);
    prog_tbl[3][6]  = i_word(op_addi, 22, 0, marker);
    prog_tbl[3][7]  = i_word(op_addi, 23, 0, marker);
    prog_tbl[3][9]  = i_word(op_addi, 3, 1, 16'd1);
    chk_reg[3] = 3;
    chk_exp[3] = 32'd10;

    // words after the halt must never retire
    test_name[4] = "zero_and_halt";
    prog_tbl[4][0]  = i_word(op_addi, 0, 0, 16'h0055);
    prog_tbl[4][1]  = r_word(op_add, 1, 0, 0);
    prog_tbl[4][2]  = i_word(op_addi, 2, 0, 16'd6);
    prog_tbl[4][3]  = r_word(op_or, 3, 0, 2);
    prog_tbl[4][4]  = halt_word;
    prog_tbl[4][5]  = i_word(op_addi, 24, 0, marker);
    prog_tbl[4][6]  = i_word(op_addi, 25, 0, marker);
    chk_reg[4] = 3;
    chk_exp[4] = 32'd6;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // reference ISA model
  ////////////////////////////////////////////////////////////////////////////

  task automatic run_model(input int t);
    int          pc;
    int          steps;
    logic [31:0] w;
    opcode_t     op;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] zimm;
    logic [31:0] ea;
    logic [31:0] res;
    logic [4:0]  dst;
    logic        wr;
    logic        done;
    for (int r = 0; r < 32; r++) begin
      model_regs[r] = '0;
    end
    exp_idx.delete();
    exp_data.delete();
    pc = 0;
    steps = 0;
    done = 1'b0;
    while (!done && steps < 200) begin
      w = (pc >= 0 && pc < prog_len) ? prog_tbl[t][pc] : halt_word;
      op = opcode_t'(w[31:26]);
      a = model_regs[w[25:21]];
      b = model_regs[w[20:16]];
      zimm = {16'd0, w[15:0]};
      ea = a + zimm;
      res = '0;
      pc = pc + 1;
      steps++;
      case (op)
        op_add:  res = a + b;
        op_sub:  res = a - b;
        op_and:  res = a & b;
        op_or:   res = a | b;
        op_xor:  res = a ^ b;
        op_slt:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        op_sll:  res = a << w[10:6];
        op_srl:  res = a >> w[10:6];
        op_addi: res = a + zimm;
        op_ori:  res = a | zimm;
        op_lw:   res = model_mem[ea[7:0]];
        op_sw:   model_mem[ea[7:0]] = b;
        op_beq:  if (a == b) pc = int'(w[7:0]);
        op_bne:  if (a != b) pc = int'(w[7:0]);
        op_j:    pc = int'(w[7:0]);
        op_jr:   pc = int'(a[7:0]);
        op_halt: done = 1'b1;
        default: ;
      endcase
      // immediates and loads write rt while register ops write rd
      wr = op inside {op_add, op_sub, op_and, op_or, op_xor, op_slt, op_sll, op_srl,
                      op_addi, op_ori, op_lw};
      dst = (op inside {op_addi, op_ori, op_lw}) ? w[20:16] : w[15:11];
      if (wr && dst != 5'd0) begin
        model_regs[dst] = res;
        exp_idx.push_back(dst);
        exp_data.push_back(res);
      end
    end
    if (!done) begin
      error_count++;
      $display("%s: reference model did not reach halt within 200 steps", test_name[t]);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // load, run and compare
  ////////////////////////////////////////////////////////////////////////////

  task automatic load_and_run(input int t);
    int cycles;
    @(posedge clk);
    #1;
    rst_n = 1'b0;
    capture = 1'b0;
    for (int i = 0; i < prog_len; i++) begin
      prog_we = 1'b1;
      prog_addr = i[imem_aw-1:0];
      prog_data = prog_tbl[t][i];
      @(posedge clk);
      #1;
    end
    prog_we = 1'b0;
    // reset held 3 cycles past the load
    repeat (3) begin
      @(posedge clk);
      #1;
    end
    got_idx.delete();
    got_data.delete();
    post_halt_writes = 0;
    capture = 1'b1;
    rst_n = 1'b1;
    cycles = 0;
    while (!halted && cycles < halt_wait) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (!halted) begin
      error_count++;
      $display("%s: halted did not rise within %0d cycles", test_name[t], halt_wait);
    end else begin
      // quiet period after halt
      repeat (20) begin
        @(posedge clk);
        #1;
      end
    end
    capture = 1'b0;
  endtask

  task automatic compare_results(input int t);
    int          n;
    logic [31:0] dut_final;
    logic [31:0] exp_final;
    check_count++;
    if (got_idx.size() != exp_idx.size()) begin
      error_count++;
      $display("mismatch %s trace write count: expected %0d actual %0d",
               test_name[t], exp_idx.size(), got_idx.size());
    end
    n = (got_idx.size() < exp_idx.size()) ? got_idx.size() : exp_idx.size();
    for (int i = 0; i < n; i++) begin
      check_count++;
      if (got_idx[i] != exp_idx[i] || got_data[i] != exp_data[i]) begin
        error_count++;
        $display("mismatch %s write %0d: expected r%0d=%08h actual r%0d=%08h",
                 test_name[t], i, exp_idx[i], exp_data[i], got_idx[i], got_data[i]);
      end
    end
    dut_final = '0;
    for (int i = 0; i < got_idx.size(); i++) begin
      if (got_idx[i] == 5'd0) begin
        error_count++;
        $display("%s: the trace port reported a write to register 0", test_name[t]);
      end
      if (got_idx[i] >= 5'd20) begin
        error_count++;
        $display("%s: marker register r%0d was written on a path that must be skipped",
                 test_name[t], got_idx[i]);
      end
      if (got_idx[i] == chk_reg[t]) begin
        dut_final = got_data[i];
      end
    end
    check_count++;
    if (post_halt_writes != 0) begin
      error_count++;
      $display("%s: %0d register writes appeared after halted rose",
               test_name[t], post_halt_writes);
    end
    exp_final = (chk_exp[t] != 32'd0) ? chk_exp[t] : model_regs[chk_reg[t]];
    check_count++;
    if (dut_final != exp_final) begin
      error_count++;
      $display("mismatch %s r%0d final value: expected %08h actual %08h",
               test_name[t], chk_reg[t], exp_final, dut_final);
    end
  endtask

  initial begin
    clk = 1'b0;
    rst_n = 1'b0;
    prog_we = 1'b0;
    prog_addr = '0;
    prog_data = '0;
    capture = 1'b0;
    post_halt_writes = 0;
    error_count = 0;
    check_count = 0;
    lfsr_state = 8'd64;
    build_table();
    for (int t = 0; t < num_tests; t++) begin
      run_model(t);
      load_and_run(t);
      compare_results(t);
    end
    $display("tests %0d, checks %0d, errors %0d", num_tests, check_count, error_count);
    if (error_count == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
cpu_pkg.sv
fetch_unit.sv
register_file.sv
decode_unit.sv
execute_unit.sv
memory_unit.sv
processor.sv
tb_processor.sv

// File: run.sh
#!/bin/sh
# build the processor testbench with Verilator, run it, and judge the log

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --timescale 1ns/1ps --top-module tb_processor \
    -Mdir obj_dir -f list.f; then
  echo "verilator build failed"
  exit 1
fi

if ! ./obj_dir/Vtb_processor > sim.log 2>&1; then
  cat sim.log
  echo "simulation exited with an error status"
  exit 1
fi

cat sim.log

if grep -q "Errors found" sim.log; then
  echo "FAIL"
  exit 1
fi

if ! grep -q "No errors" sim.log; then
  echo "FAIL: no verdict in sim.log"
  exit 1
fi

echo "PASS"
exit 0
